//--- dv/ClockGen.sv
// Testbench clock and reset source: 100 ns clock, reset held low for the first 4 cycles
module ClockGen (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #10 rstN = 1'b1;
    end

endmodule

//--- dv/MemModel.sv
// Behavioral external memory for the testbench: serials, random busy, out-of-order read returns
module MemModel #(
    parameter logic [63:0] initKey = '0
) (
    input  logic clk,
    input  logic rstN,
    input  logic randomBusy,
    input  logic holdBusy,
    input  MemSysTypes::PhyAddr memAccessAddr,
    input  MemSysTypes::MemEntryData memAccessWriteData,
    input  logic memAccessRE,
    input  logic memAccessWE,
    output MemSysTypes::MemReadSerial nextMemReadSerial,
    output MemSysTypes::MemWriteSerial nextMemWriteSerial,
    output logic memReadDataReady,
    output MemSysTypes::MemEntryData memReadData,
    output MemSysTypes::MemReadSerial memReadSerial,
    output MemSysTypes::MemAccessResponse memAccessResponse,
    output logic memAccessReadBusy,
    output logic memAccessWriteBusy
);
    timeunit 1ns;
    timeprecision 100ps;

    MemSysTypes::MemEntryData mem [MemSysTypes::PhyAddr];
    logic pend [MemSysTypes::READ_SERIAL_NUM];
    MemSysTypes::MemEntryData rdata [MemSysTypes::READ_SERIAL_NUM];
    int lat [MemSysTypes::READ_SERIAL_NUM];
    MemSysTypes::MemWriteSerial wSer [$];
    int wDue [$];
    int cycle;
    logic issuedRead;
    logic issuedWrite;

    function automatic MemSysTypes::MemEntryData readEntry(input MemSysTypes::PhyAddr a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return MemSysTypes::MemEntryData'(a) ^ initKey;
    endfunction

    task automatic pickReadReturn();
        int start;
        int s;
        memReadDataReady = 1'b0;
        start = int'($urandom % MemSysTypes::READ_SERIAL_NUM);
        for (int i = 0; i < MemSysTypes::READ_SERIAL_NUM; i++) begin
            s = (start + i) % MemSysTypes::READ_SERIAL_NUM;
            if (!memReadDataReady && pend[s] && lat[s] <= 0) begin
                memReadDataReady = 1'b1;
                memReadSerial = MemSysTypes::MemReadSerial'(s);
                memReadData = rdata[s];
                pend[s] = 1'b0;
            end
        end
    endtask

    initial begin
        nextMemReadSerial = '0;
        nextMemWriteSerial = '0;
        memReadDataReady = 1'b0;
        memReadData = '0;
        memReadSerial = '0;
        memAccessResponse = '0;
        memAccessReadBusy = 1'b0;
        memAccessWriteBusy = 1'b0;
        cycle = 0;
        for (int i = 0; i < MemSysTypes::READ_SERIAL_NUM; i++) begin
            pend[i] = 1'b0;
            lat[i] = 0;
        end
        forever begin
            // Strobes are sampled mid-cycle, where they are stable
            @(negedge clk);
            issuedRead = 1'b0;
            issuedWrite = 1'b0;
            if (rstN && memAccessRE) begin
                pend[nextMemReadSerial] = 1'b1;
                rdata[nextMemReadSerial] = readEntry(memAccessAddr);
                lat[nextMemReadSerial] = 1 + int'($urandom % 8);
                issuedRead = 1'b1;
            end
            if (rstN && memAccessWE) begin
                mem[memAccessAddr] = memAccessWriteData;
                wSer.push_back(nextMemWriteSerial);
                wDue.push_back(cycle + 1 + int'($urandom % 6));
                issuedWrite = 1'b1;
            end
            @(posedge clk);
            #10;
            cycle++;
            if (issuedRead) nextMemReadSerial = nextMemReadSerial + 1'b1;
            if (issuedWrite) nextMemWriteSerial = nextMemWriteSerial + 1'b1;
            for (int i = 0; i < MemSysTypes::READ_SERIAL_NUM; i++) begin
                if (pend[i]) lat[i]--;
            end
            pickReadReturn();
            memAccessResponse = '0;
            if (wSer.size() != 0 && wDue[0] <= cycle) begin
                memAccessResponse.valid = 1'b1;
                memAccessResponse.serial = wSer.pop_front();
                void'(wDue.pop_front());
            end
            memAccessReadBusy = holdBusy || (randomBusy && ($urandom % 3 == 0));
            memAccessWriteBusy = holdBusy || (randomBusy && ($urandom % 3 == 0));
        end
    end

endmodule

//--- dv/TbMemSubsystem.sv
// Testbench top for MemSubsystem that drives both requesters against a memory model and checks responses
module TbMemSubsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [63:0] MEM_INIT_KEY = 64'h3c5a_96f0_0ff0_a5c3;
    // Requests issued over all tests, in test order
    localparam int TOTAL_REQUESTS = 12 + 2 * 8 + 4 + 10 + 2 * MemSysTypes::QUEUE_DEPTH + 2 * 16;
    localparam int CYCLES_PER_REQUEST = 200;
    localparam int CLK_PERIOD_NS = 100;

    logic clk, rstN, randomBusy, holdBusy;
    logic fetchMissValid, fetchMissFull, fetchFillValid;
    MemSysTypes::PhyAddr fetchMissAddr, fetchFillAddr, dataReadAddr, memAccessAddr;
    MemSysTypes::MemEntryData fetchFillData, dataReadData, memAccessWriteData, memReadData;
    logic dataReqValid, dataReqFull, dataReadValid, dataWriteDone, serialWE;
    MemSysTypes::DataReq dataReq;
    MemSysTypes::SerialData serialWriteData;
    logic memAccessRE, memAccessWE, memReadDataReady, memAccessReadBusy, memAccessWriteBusy;
    MemSysTypes::MemReadSerial nextMemReadSerial, memReadSerial;
    MemSysTypes::MemWriteSerial nextMemWriteSerial;
    MemSysTypes::MemAccessResponse memAccessResponse;

    int errors, testsRun, fetchOutstanding, readsOutstanding, writesIssued, writesDone;
    int writeSlot;
    MemSysTypes::MemEntryData refMem [MemSysTypes::PhyAddr];
    int fetchPending [MemSysTypes::PhyAddr];
    int readsPending [MemSysTypes::PhyAddr];
    MemSysTypes::SerialData serialExp [$];

    ClockGen clockGen (.*);
    MemModel #(.initKey(MEM_INIT_KEY)) memModel (.*);
    MemSubsystem dut_i (.*);

    function automatic MemSysTypes::MemEntryData expectedEntry(input MemSysTypes::PhyAddr a);
        if (refMem.exists(a)) begin
            return refMem[a];
        end
        return MemSysTypes::MemEntryData'(a) ^ MEM_INIT_KEY;
    endfunction

    task automatic reportMismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
        errors++;
        $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic reportProblem(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // Memory port protocol
    assert property (@(posedge clk) disable iff (!rstN) memAccessRE |-> !$past(memAccessReadBusy))
        else reportProblem("memAccessRE rose after a cycle with memAccessReadBusy high");
    assert property (@(posedge clk) disable iff (!rstN) memAccessWE |-> !$past(memAccessWriteBusy))
        else reportProblem("memAccessWE rose after a cycle with memAccessWriteBusy high");
    assert property (@(posedge clk) disable iff (!rstN) !(memAccessRE && memAccessWE))
        else reportProblem("memAccessRE and memAccessWE high in the same cycle");
    assert property (@(posedge clk) disable iff (!rstN) memAccessWE |-> !memAccessAddr[31])
        else reportProblem("an I/O-range write reached the memory port");

    // Responses are checked and retired mid-cycle
    always @(negedge clk) begin
        logic known;
        if (rstN && fetchFillValid) begin
            assert (fetchFillData == expectedEntry(fetchFillAddr))
                else reportMismatch("fetchFillData", expectedEntry(fetchFillAddr), fetchFillData);
            known = fetchPending.exists(fetchFillAddr) && fetchPending[fetchFillAddr] > 0;
            assert (known) else reportProblem("fetch fill for an address with no pending miss");
            if (known) begin
                fetchPending[fetchFillAddr]--;
                fetchOutstanding--;
            end
        end
        if (rstN && dataReadValid) begin
            assert (dataReadData == expectedEntry(dataReadAddr))
                else reportMismatch("dataReadData", expectedEntry(dataReadAddr), dataReadData);
            known = readsPending.exists(dataReadAddr) && readsPending[dataReadAddr] > 0;
            assert (known)
                else reportProblem("data read return for an address with no pending read");
            if (known) begin
                readsPending[dataReadAddr]--;
                readsOutstanding--;
            end
        end
        if (rstN && dataWriteDone) begin
            writesDone++;
            assert (writesDone <= writesIssued)
                else reportProblem("more write completions than writes");
        end
        if (rstN && serialWE) begin
            assert (serialExp.size() != 0)
                else reportProblem("serial byte written with no I/O write pending");
            if (serialExp.size() != 0) begin
                assert (serialWriteData == serialExp[0])
                    else reportMismatch("serialWriteData", 64'(serialExp[0]),
                                        64'(serialWriteData));
                void'(serialExp.pop_front());
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    task automatic issueFetchMiss(input MemSysTypes::PhyAddr a);
        MemSysTypes::PhyAddr aligned;
        while (fetchMissFull) nextCycle();
        // Refills cover one 8-byte entry
        aligned = {a[31:3], 3'b000};
        fetchPending[aligned] = fetchPending.exists(aligned) ? fetchPending[aligned] + 1 : 1;
        fetchOutstanding++;
        fetchMissValid = 1'b1;
        fetchMissAddr = a;
        nextCycle();
        fetchMissValid = 1'b0;
    endtask

    task automatic issueDataReq(input MemSysTypes::PhyAddr a, input logic w,
                                input MemSysTypes::MemEntryData d);
        while (dataReqFull) nextCycle();
        if (w) begin
            writesIssued++;
            if (a[31]) serialExp.push_back(d[7:0]);
            else refMem[a] = d;
        end else begin
            readsPending[a] = readsPending.exists(a) ? readsPending[a] + 1 : 1;
            readsOutstanding++;
        end
        dataReqValid = 1'b1;
        dataReq = '{addr: a, isWrite: w, writeData: d};
        nextCycle();
        dataReqValid = 1'b0;
    endtask

    task automatic waitQuiet();
        while (fetchOutstanding != 0 || readsOutstanding != 0 || writesDone != writesIssued ||
               serialExp.size() != 0) begin
            nextCycle();
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        $display("Test %s finished, %0d failed checks so far", name, errors);
    endtask

    function automatic MemSysTypes::MemEntryData randomEntry();
        return {$urandom, $urandom};
    endfunction

    function automatic MemSysTypes::PhyAddr untouchedAddr();
        return MemSysTypes::PhyAddr'(32'h2000 + ($urandom % 64) * 8);
    endfunction

    initial begin
        int base;
        MemSysTypes::PhyAddr a;
        void'($urandom(32'h5dae0cf8));
        fetchMissValid = 1'b0;
        fetchMissAddr = '0;
        dataReqValid = 1'b0;
        dataReq = '0;
        randomBusy = 1'b0;
        holdBusy = 1'b0;
        errors = 0;
        writeSlot = 0;
        wait (rstN);
        nextCycle();
        assert (!(memAccessRE || memAccessWE || fetchFillValid || dataReadValid ||
                  dataWriteDone || serialWE)) else reportProblem("a strobe is high after reset");
        assert (!(fetchMissFull || dataReqFull))
            else reportProblem("a full level is high after reset");
        finishTest("reset");

        for (int i = 0; i < 12; i++) issueFetchMiss(MemSysTypes::PhyAddr'($urandom % 32'h1000));
        waitQuiet();
        finishTest("fetch refill");

        base = int'($urandom % 32);
        for (int i = 0; i < 8; i++) begin
            a = MemSysTypes::PhyAddr'(32'h1000 + (base + i) * 8);
            issueDataReq(a, 1'b1, randomEntry());
            issueDataReq(a, 1'b0, '0);
        end
        for (int i = 0; i < 4; i++) issueDataReq(untouchedAddr(), 1'b0, '0);
        waitQuiet();
        finishTest("data read after write");

        for (int i = 0; i < 10; i++) begin
            if (i % 3 != 2) begin
                issueDataReq(32'h8000_0000 | ($urandom % 32'h100), 1'b1, randomEntry());
            end else begin
                issueDataReq(MemSysTypes::PhyAddr'(32'h3000 + writeSlot * 8), 1'b1,
                             randomEntry());
                writeSlot++;
            end
        end
        waitQuiet();
        finishTest("serial I/O writes");

        // Blocked memory must fill both queues
        holdBusy = 1'b1;
        repeat (2) nextCycle();
        for (int i = 0; i < MemSysTypes::QUEUE_DEPTH; i++) begin
            issueFetchMiss(MemSysTypes::PhyAddr'($urandom % 32'h1000));
            issueDataReq(MemSysTypes::PhyAddr'(32'h1000 + (base + i) * 8), 1'b0, '0);
        end
        assert (fetchMissFull) else reportProblem("fetchMissFull low with a blocked full queue");
        assert (dataReqFull) else reportProblem("dataReqFull low with a blocked full queue");
        holdBusy = 1'b0;
        randomBusy = 1'b1;
        fork
            for (int i = 0; i < 16; i++) begin
                issueFetchMiss(MemSysTypes::PhyAddr'($urandom % 32'h1000));
            end
            for (int i = 0; i < 16; i++) begin
                case ($urandom % 3)
                    0: issueDataReq(untouchedAddr(), 1'b0, '0);
                    1: begin
                        issueDataReq(MemSysTypes::PhyAddr'(32'h3000 + writeSlot * 8), 1'b1,
                                     randomEntry());
                        writeSlot++;
                    end
                    default: issueDataReq(32'h8000_0000 | ($urandom % 32'h100), 1'b1,
                                          randomEntry());
                endcase
            end
        join
        waitQuiet();
        randomBusy = 1'b0;
        finishTest("busy back-pressure");

        $display("Tests run %0d, writes %0d, completions %0d, failed checks %0d",
                 testsRun, writesIssued, writesDone, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD_NS * CYCLES_PER_REQUEST * TOTAL_REQUESTS);
        $display("Timeout: requests were still outstanding when the time limit ran out");
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
hw/MemSysTypes.sv
hw/RequestQueue.sv
hw/FetchRefillUnit.sv
hw/DataAccessUnit.sv
hw/MemAccessArbiter.sv
hw/MemoryAccessController.sv
hw/MemSubsystem.sv
dv/ClockGen.sv
dv/MemModel.sv
dv/TbMemSubsystem.sv

//--- hw/DataAccessUnit.sv
// Data side: buffers loads and stores, sends memory accesses to the arbiter, serial I/O itself
module DataAccessUnit (
    input  logic clk,
    input  logic rstN,
    input  logic dataReqValid,
    input  MemSysTypes::DataReq dataReq,
    output logic dataReqFull,
    output MemSysTypes::MemReq dataOffer,
    input  logic dataGrant,
    input  logic writeDoneFromMem,
    output logic dataWriteDone,
    output logic serialWE,
    output MemSysTypes::SerialData serialWriteData
);

    MemSysTypes::DataReq headReq;
    logic headValid;
    logic headIsIoWrite;
    logic ioPop;
    MemSysTypes::IoDoneCount ioOwed;
    MemSysTypes::IoDoneCount ioPendingCount;
    logic ioDoneNow;

    RequestQueue #(
        .EntryT(MemSysTypes::DataReq)
    ) reqQueue (
        .clk(clk),
        .rstN(rstN),
        .push(dataReqValid),
        .pushData(dataReq),
        .pop(dataGrant || ioPop),
        .head(headReq),
        .notEmpty(headValid),
        .full(dataReqFull)
    );

    assign headIsIoWrite = headReq.isWrite && (headReq.addr >= MemSysTypes::IO_BASE_ADDR);

    // I/O writes leave from the head only, so they stay in order with memory requests
    assign ioPop = headValid && headIsIoWrite;

    always_comb begin
        dataOffer = '0;
        dataOffer.valid = headValid && !headIsIoWrite;
        dataOffer.addr = headReq.addr;
        dataOffer.isWrite = headReq.isWrite;
        dataOffer.writeData = headReq.writeData;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            serialWE <= 1'b0;
        end else begin
            serialWE <= ioPop;
        end
    end

    // Low byte of the store goes out on the serial port
    always_ff @(posedge clk) begin
        if (ioPop) begin
            serialWriteData <= headReq.writeData[$bits(MemSysTypes::SerialData)-1:0];
        end
    end

    // Memory completions go first, an I/O completion waits for a free cycle
    assign ioPendingCount = ioOwed + MemSysTypes::IoDoneCount'(serialWE);
    assign ioDoneNow = !writeDoneFromMem && (ioPendingCount != '0);
    assign dataWriteDone = writeDoneFromMem || ioDoneNow;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ioOwed <= '0;
        end else begin
            ioOwed <= ioPendingCount - MemSysTypes::IoDoneCount'(ioDoneNow);
        end
    end

endmodule

//--- hw/FetchRefillUnit.sv
// Instruction refill side: buffers fetch miss addresses and offers them as memory reads
module FetchRefillUnit (
    input  logic clk,
    input  logic rstN,
    input  logic fetchMissValid,
    input  MemSysTypes::PhyAddr fetchMissAddr,
    output logic fetchMissFull,
    output MemSysTypes::MemReq fetchOffer,
    input  logic fetchGrant
);

    MemSysTypes::PhyAddr alignedMissAddr;
    MemSysTypes::PhyAddr headAddr;
    logic headValid;

    // Refills always cover a whole entry
    assign alignedMissAddr = fetchMissAddr & ~MemSysTypes::ENTRY_OFFSET_MASK;

    RequestQueue #(
        .EntryT(MemSysTypes::PhyAddr)
    ) missQueue (
        .clk(clk),
        .rstN(rstN),
        .push(fetchMissValid),
        .pushData(alignedMissAddr),
        .pop(fetchGrant),
        .head(headAddr),
        .notEmpty(headValid),
        .full(fetchMissFull)
    );

    always_comb begin
        fetchOffer = '0;
        fetchOffer.valid = headValid;
        fetchOffer.addr = headAddr;
        fetchOffer.isWrite = 1'b0;
    end

endmodule

//--- hw/MemAccessArbiter.sv
// Round-robin arbiter that picks one requester offer per cycle for the memory port
module MemAccessArbiter (
    input  logic clk,
    input  logic rstN,
    input  MemSysTypes::MemReq fetchOffer,
    input  MemSysTypes::MemReq dataOffer,
    input  logic memAccessReadBusy,
    input  logic memAccessWriteBusy,
    input  logic readSerialFree,
    output logic fetchGrant,
    output logic dataGrant,
    output MemSysTypes::MemReq grantReq,
    output MemSysTypes::ReqOwner grantOwner
);

    logic fetchEligible;
    logic dataEligible;
    logic pickData;
    MemSysTypes::ReqOwner priorityOwner;

    // Reads also need a free slot in the serial table
    function automatic logic offerEligible(
        input MemSysTypes::MemReq offer,
        input logic readBusy,
        input logic writeBusy,
        input logic serialFree
    );
        if (offer.isWrite) begin
            return offer.valid && !writeBusy;
        end
        return offer.valid && !readBusy && serialFree;
    endfunction

    assign fetchEligible = offerEligible(fetchOffer, memAccessReadBusy, memAccessWriteBusy,
                                         readSerialFree);
    assign dataEligible = offerEligible(dataOffer, memAccessReadBusy, memAccessWriteBusy,
                                        readSerialFree);

    assign pickData = dataEligible &&
                      (!fetchEligible || priorityOwner == MemSysTypes::OWNER_DATA);
    assign dataGrant = pickData;
    assign fetchGrant = fetchEligible && !pickData;
    assign grantOwner = pickData ? MemSysTypes::OWNER_DATA : MemSysTypes::OWNER_FETCH;

    always_comb begin
        grantReq = pickData ? dataOffer : fetchOffer;
        grantReq.valid = fetchGrant || dataGrant;
    end

    // Priority passes to the other side after each grant
    always_ff @(posedge clk) begin
        if (!rstN) begin
            priorityOwner <= MemSysTypes::OWNER_FETCH;
        end else if (dataGrant) begin
            priorityOwner <= MemSysTypes::OWNER_FETCH;
        end else if (fetchGrant) begin
            priorityOwner <= MemSysTypes::OWNER_DATA;
        end
    end

endmodule

//--- hw/MemSubsystem.sv
// Top of the memory subsystem: both requesters, the arbiter and the memory port controller
module MemSubsystem (
    input  logic clk,
    input  logic rstN,
    input  logic fetchMissValid,
    input  MemSysTypes::PhyAddr fetchMissAddr,
    output logic fetchMissFull,
    output logic fetchFillValid,
    output MemSysTypes::PhyAddr fetchFillAddr,
    output MemSysTypes::MemEntryData fetchFillData,
    input  logic dataReqValid,
    input  MemSysTypes::DataReq dataReq,
    output logic dataReqFull,
    output logic dataReadValid,
    output MemSysTypes::PhyAddr dataReadAddr,
    output MemSysTypes::MemEntryData dataReadData,
    output logic dataWriteDone,
    output logic serialWE,
    output MemSysTypes::SerialData serialWriteData,
    output MemSysTypes::PhyAddr memAccessAddr,
    output MemSysTypes::MemEntryData memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    input  MemSysTypes::MemReadSerial nextMemReadSerial,
    input  MemSysTypes::MemWriteSerial nextMemWriteSerial,
    input  logic memReadDataReady,
    input  MemSysTypes::MemEntryData memReadData,
    input  MemSysTypes::MemReadSerial memReadSerial,
    input  MemSysTypes::MemAccessResponse memAccessResponse,
    input  logic memAccessReadBusy,
    input  logic memAccessWriteBusy
);

    MemSysTypes::MemReq fetchOffer;
    MemSysTypes::MemReq dataOffer;
    MemSysTypes::MemReq grantReq;
    MemSysTypes::ReqOwner grantOwner;
    logic fetchGrant;
    logic dataGrant;
    logic readSerialFree;
    logic writeDoneFromMem;

    FetchRefillUnit fetchRefillUnit (.*);
    DataAccessUnit dataAccessUnit (.*);
    MemAccessArbiter memAccessArbiter (.*);
    MemoryAccessController memoryAccessController (.*);

endmodule

//--- hw/MemSysTypes.sv
// Shared types and constants of the memory subsystem, referenced by scoped name from every file
package MemSysTypes;

    localparam int READ_SERIAL_NUM = 16;
    localparam int WRITE_SERIAL_NUM = 16;

    typedef logic [31:0] PhyAddr;
    typedef logic [63:0] MemEntryData;
    typedef logic [$clog2(READ_SERIAL_NUM)-1:0] MemReadSerial;
    typedef logic [$clog2(WRITE_SERIAL_NUM)-1:0] MemWriteSerial;
    typedef logic [7:0] SerialData;

    // Bytes per memory entry and the low address bits inside one entry
    localparam int MEM_ENTRY_BYTES = $bits(MemEntryData) / 8;
    localparam PhyAddr ENTRY_OFFSET_MASK = PhyAddr'(MEM_ENTRY_BYTES - 1);

    // I/O range is the upper half of the address space
    localparam PhyAddr IO_BASE_ADDR = 32'h8000_0000;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_COUNT_BITS = $clog2(QUEUE_DEPTH + 1);
    typedef logic [QUEUE_PTR_BITS-1:0] QueuePtr;
    typedef logic [QUEUE_COUNT_BITS-1:0] QueueCount;
    localparam QueuePtr QUEUE_LAST_PTR = QueuePtr'(QUEUE_DEPTH - 1);
    localparam QueueCount QUEUE_FULL_COUNT = QueueCount'(QUEUE_DEPTH);

    // Outstanding writes per serial, and I/O completions waiting for a free slot
    localparam int WRITE_COUNT_BITS = 6;
    localparam int IO_DONE_COUNT_BITS = 4;
    typedef logic [WRITE_COUNT_BITS-1:0] WriteCount;
    typedef logic [IO_DONE_COUNT_BITS-1:0] IoDoneCount;

    typedef struct packed {
        logic valid;
        MemWriteSerial serial;
    } MemAccessResponse;

    typedef struct packed {
        PhyAddr addr;
        logic isWrite;
        MemEntryData writeData;
    } DataReq;

    typedef struct packed {
        logic valid;
        PhyAddr addr;
        logic isWrite;
        MemEntryData writeData;
    } MemReq;

    typedef enum logic {
        OWNER_FETCH = 1'b0,
        OWNER_DATA = 1'b1
    } ReqOwner;

    // What the controller remembers about a read in flight
    typedef struct packed {
        ReqOwner owner;
        PhyAddr addr;
    } ReadTag;

endpackage

//--- hw/MemoryAccessController.sv
// Drives the external memory port and routes read returns and write completions back
module MemoryAccessController (
    input  logic clk,
    input  logic rstN,
    input  MemSysTypes::MemReq grantReq,
    input  MemSysTypes::ReqOwner grantOwner,
    output logic readSerialFree,
    output MemSysTypes::PhyAddr memAccessAddr,
    output MemSysTypes::MemEntryData memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    input  MemSysTypes::MemReadSerial nextMemReadSerial,
    input  MemSysTypes::MemWriteSerial nextMemWriteSerial,
    input  logic memReadDataReady,
    input  MemSysTypes::MemEntryData memReadData,
    input  MemSysTypes::MemReadSerial memReadSerial,
    input  MemSysTypes::MemAccessResponse memAccessResponse,
    input  logic memAccessReadBusy,
    input  logic memAccessWriteBusy,
    output logic fetchFillValid,
    output MemSysTypes::PhyAddr fetchFillAddr,
    output MemSysTypes::MemEntryData fetchFillData,
    output logic dataReadValid,
    output MemSysTypes::PhyAddr dataReadAddr,
    output MemSysTypes::MemEntryData dataReadData,
    output logic writeDoneFromMem
);

    logic [MemSysTypes::READ_SERIAL_NUM-1:0] readPending;
    MemSysTypes::ReadTag readTags [MemSysTypes::READ_SERIAL_NUM];
    MemSysTypes::ReqOwner issueOwner;
    MemSysTypes::MemReadSerial assignSerial;
    logic returnHit;
    logic retValid;
    MemSysTypes::ReadTag retTag;
    MemSysTypes::MemEntryData retData;
    MemSysTypes::WriteCount writeCounts [MemSysTypes::WRITE_SERIAL_NUM];
    logic writeRespHit;

    // Serial the next granted read will receive, one ahead while a read strobe is out
    assign assignSerial = memAccessRE ? nextMemReadSerial + 1'b1 : nextMemReadSerial;
    assign readSerialFree = !readPending[assignSerial];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memAccessRE <= 1'b0;
            memAccessWE <= 1'b0;
        end else begin
            memAccessRE <= grantReq.valid && !grantReq.isWrite && !memAccessReadBusy;
            memAccessWE <= grantReq.valid && grantReq.isWrite && !memAccessWriteBusy;
        end
    end

    always_ff @(posedge clk) begin
        memAccessAddr <= grantReq.addr;
        memAccessWriteData <= grantReq.writeData;
        issueOwner <= grantOwner;
    end

    // Read table, filled on issue and released on return
    assign returnHit = memReadDataReady && readPending[memReadSerial];

    always_ff @(posedge clk) begin
        if (memAccessRE) begin
            readTags[nextMemReadSerial] <= '{owner: issueOwner, addr: memAccessAddr};
        end
        if (returnHit) begin
            retTag <= readTags[memReadSerial];
            retData <= memReadData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPending <= '0;
            retValid <= 1'b0;
        end else begin
            retValid <= returnHit;
            if (returnHit) begin
                readPending[memReadSerial] <= 1'b0;
            end
            if (memAccessRE) begin
                readPending[nextMemReadSerial] <= 1'b1;
            end
        end
    end

    assign fetchFillValid = retValid && retTag.owner == MemSysTypes::OWNER_FETCH;
    assign fetchFillAddr = retTag.addr;
    assign fetchFillData = retData;
    assign dataReadValid = retValid && retTag.owner == MemSysTypes::OWNER_DATA;
    assign dataReadAddr = retTag.addr;
    assign dataReadData = retData;

    // Count writes per serial so only responses to issued writes complete
    assign writeRespHit = memAccessResponse.valid &&
                          writeCounts[memAccessResponse.serial] != '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            writeDoneFromMem <= 1'b0;
            for (int i = 0; i < MemSysTypes::WRITE_SERIAL_NUM; i++) begin
                writeCounts[i] <= '0;
            end
        end else begin
            writeDoneFromMem <= writeRespHit;
            for (int i = 0; i < MemSysTypes::WRITE_SERIAL_NUM; i++) begin
                writeCounts[i] <= writeCounts[i]
                    + MemSysTypes::WriteCount'(memAccessWE &&
                        nextMemWriteSerial == MemSysTypes::MemWriteSerial'(i))
                    - MemSysTypes::WriteCount'(writeRespHit &&
                        memAccessResponse.serial == MemSysTypes::MemWriteSerial'(i));
            end
        end
    end

endmodule

//--- hw/RequestQueue.sv
// Small circular FIFO for requester-side queues, entry type chosen by parameter
module RequestQueue #(
    parameter type EntryT = logic
) (
    input  logic clk,
    input  logic rstN,
    input  logic push,
    input  EntryT pushData,
    input  logic pop,
    output EntryT head,
    output logic notEmpty,
    output logic full
);

    EntryT entries [MemSysTypes::QUEUE_DEPTH];
    MemSysTypes::QueuePtr readPtr;
    MemSysTypes::QueuePtr writePtr;
    MemSysTypes::QueueCount count;
    logic doPush;
    logic doPop;

    assign notEmpty = count != '0;
    assign full = count == MemSysTypes::QUEUE_FULL_COUNT;
    assign doPush = push && !full;
    assign doPop = pop && notEmpty;
    assign head = entries[readPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[writePtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPtr <= '0;
            writePtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                writePtr <= (writePtr == MemSysTypes::QUEUE_LAST_PTR) ? '0 : writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= (readPtr == MemSysTypes::QUEUE_LAST_PTR) ? '0 : readPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the MemSubsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module TbMemSubsystem \
    -Mdir obj_dir -o simTb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
